// File: logic/lcd_pkg.sv
package lcd_pkg;

	// Control bus window, base aligned to 16 bytes
	localparam int CTRL_ADDR_W = 16;
	localparam logic [CTRL_ADDR_W-1:0] LCD_BASE_ADDR = 16'h0040;

	// Register offsets inside the window
	localparam logic [3:0] REG_CTRL       = 4'h0;
	localparam logic [3:0] REG_H_RES_LOW  = 4'h1;
	localparam logic [3:0] REG_H_RES_HIGH = 4'h2;
	localparam logic [3:0] REG_H_PULSE    = 4'h3;
	localparam logic [3:0] REG_H_BACK     = 4'h4;
	localparam logic [3:0] REG_H_FRONT    = 4'h5;
	localparam logic [3:0] REG_V_RES_LOW  = 4'h6;
	localparam logic [3:0] REG_V_RES_HIGH = 4'h7;
	localparam logic [3:0] REG_V_PULSE    = 4'h8;
	localparam logic [3:0] REG_V_BACK     = 4'h9;
	localparam logic [3:0] REG_V_FRONT    = 4'hA;
	localparam logic [3:0] REG_PIXEL_SIZE = 4'hB;

	// Line and frame counters
	localparam int CNT_W = 13;
	typedef logic [CNT_W-1:0] cnt_t;

	// Pixel size codes, anything else is 24-bit
	localparam logic [7:0] PIX_8  = 8'd8;
	localparam logic [7:0] PIX_16 = 8'd16;

	// Values loaded on reset
	localparam logic [15:0] RST_H_RES      = 16'd800;
	localparam logic [7:0]  RST_H_PULSE    = 8'd2;
	localparam logic [7:0]  RST_H_BACK     = 8'd46;
	localparam logic [7:0]  RST_H_FRONT    = 8'd210;
	localparam logic [15:0] RST_V_RES      = 16'd480;
	localparam logic [7:0]  RST_V_PULSE    = 8'd2;
	localparam logic [7:0]  RST_V_BACK     = 8'd23;
	localparam logic [7:0]  RST_V_FRONT    = 8'd22;
	localparam logic [7:0]  RST_PIXEL_SIZE = 8'd16;
	localparam logic        RST_EN         = 1'b0;

	typedef struct packed {
		logic [15:0] h_res;
		logic [7:0]  h_pulse;
		logic [7:0]  h_back;
		logic [7:0]  h_front;
		logic [15:0] v_res;
		logic [7:0]  v_pulse;
		logic [7:0]  v_back;
		logic [7:0]  v_front;
	} lcd_timing_cfg_t;

	typedef struct packed {
		logic hsync_inv;
		logic vsync_inv;
		logic de_inv;
	} lcd_polarity_t;

	localparam lcd_polarity_t RST_POL = '{hsync_inv: 1'b1, vsync_inv: 1'b1, de_inv: 1'b0};

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} lcd_raw_sync_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} lcd_rgb_t;

	// Views of the color word, red always at the low end
	typedef struct packed {
		logic [7:0] pad;
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} lcd_pix24_t;

	typedef struct packed {
		logic [15:0] pad;
		logic [4:0]  b;
		logic [5:0]  g;
		logic [4:0]  r;
	} lcd_pix565_t;

	typedef struct packed {
		logic [23:0] pad;
		logic [2:0]  b;
		logic [1:0]  g;
		logic [2:0]  r;
	} lcd_pix323_t;

	typedef union packed {
		logic [31:0] raw;
		lcd_pix24_t  rgb24;
		lcd_pix565_t rgb565;
		lcd_pix323_t rgb323;
	} lcd_pixel_u;

endpackage

// File: logic/lcd_regs.sv
module lcd_regs (
	input  logic                              rst,
	input  logic                              ctrl_clk,
	input  logic [lcd_pkg::CTRL_ADDR_W-1:0]   ctrl_addr,
	input  logic                              ctrl_wr,
	input  logic                              ctrl_rd,
	input  logic [7:0]                        ctrl_data_in,
	output logic [7:0]                        ctrl_data_out,
	output lcd_pkg::lcd_timing_cfg_t          cfg,
	output lcd_pkg::lcd_polarity_t            pol,
	output logic                              en,
	output logic [7:0]                        pixel_size
);

	logic       in_win;
	logic       wr_sel;
	logic       rd_sel;
	logic [3:0] offset;
	logic [7:0] res_stage;

	// Window is 16 bytes on an aligned base
	assign in_win = (ctrl_addr[lcd_pkg::CTRL_ADDR_W-1:4] ==
		lcd_pkg::LCD_BASE_ADDR[lcd_pkg::CTRL_ADDR_W-1:4]);
	assign wr_sel = in_win && ctrl_wr;
	assign rd_sel = in_win && ctrl_rd;
	assign offset = ctrl_addr[3:0];

	always_ff @(posedge ctrl_clk or posedge rst)
	begin
		if (rst)
		begin
			en          <= lcd_pkg::RST_EN;
			pol         <= lcd_pkg::RST_POL;
			cfg.h_res   <= lcd_pkg::RST_H_RES;
			cfg.h_pulse <= lcd_pkg::RST_H_PULSE;
			cfg.h_back  <= lcd_pkg::RST_H_BACK;
			cfg.h_front <= lcd_pkg::RST_H_FRONT;
			cfg.v_res   <= lcd_pkg::RST_V_RES;
			cfg.v_pulse <= lcd_pkg::RST_V_PULSE;
			cfg.v_back  <= lcd_pkg::RST_V_BACK;
			cfg.v_front <= lcd_pkg::RST_V_FRONT;
			pixel_size  <= lcd_pkg::RST_PIXEL_SIZE;
			res_stage   <= 8'h00;
		end
		else if (wr_sel)
		begin
			case (offset)
				lcd_pkg::REG_CTRL:
				begin
					en            <= ctrl_data_in[0];
					pol.de_inv    <= ctrl_data_in[1];
					pol.vsync_inv <= ctrl_data_in[2];
					pol.hsync_inv <= ctrl_data_in[3];
				end
				// High bytes wait here until the low byte arrives
				lcd_pkg::REG_H_RES_HIGH,
				lcd_pkg::REG_V_RES_HIGH: res_stage <= ctrl_data_in;
				lcd_pkg::REG_H_RES_LOW:  cfg.h_res <= {res_stage, ctrl_data_in};
				lcd_pkg::REG_V_RES_LOW:  cfg.v_res <= {res_stage, ctrl_data_in};
				lcd_pkg::REG_H_PULSE:    cfg.h_pulse <= ctrl_data_in;
				lcd_pkg::REG_H_BACK:     cfg.h_back <= ctrl_data_in;
				lcd_pkg::REG_H_FRONT:    cfg.h_front <= ctrl_data_in;
				lcd_pkg::REG_V_PULSE:    cfg.v_pulse <= ctrl_data_in;
				lcd_pkg::REG_V_BACK:     cfg.v_back <= ctrl_data_in;
				lcd_pkg::REG_V_FRONT:    cfg.v_front <= ctrl_data_in;
				lcd_pkg::REG_PIXEL_SIZE: pixel_size <= ctrl_data_in;
				default: ;
			endcase
		end
	end

	// Readback, high-byte offsets return the committed value
	always_comb
	begin
		ctrl_data_out = 8'h00;
		if (rd_sel)
		begin
			case (offset)
				lcd_pkg::REG_CTRL:
					ctrl_data_out = {4'h0, pol.hsync_inv, pol.vsync_inv, pol.de_inv, en};
				lcd_pkg::REG_H_RES_LOW:  ctrl_data_out = cfg.h_res[7:0];
				lcd_pkg::REG_H_RES_HIGH: ctrl_data_out = cfg.h_res[15:8];
				lcd_pkg::REG_H_PULSE:    ctrl_data_out = cfg.h_pulse;
				lcd_pkg::REG_H_BACK:     ctrl_data_out = cfg.h_back;
				lcd_pkg::REG_H_FRONT:    ctrl_data_out = cfg.h_front;
				lcd_pkg::REG_V_RES_LOW:  ctrl_data_out = cfg.v_res[7:0];
				lcd_pkg::REG_V_RES_HIGH: ctrl_data_out = cfg.v_res[15:8];
				lcd_pkg::REG_V_PULSE:    ctrl_data_out = cfg.v_pulse;
				lcd_pkg::REG_V_BACK:     ctrl_data_out = cfg.v_back;
				lcd_pkg::REG_V_FRONT:    ctrl_data_out = cfg.v_front;
				lcd_pkg::REG_PIXEL_SIZE: ctrl_data_out = pixel_size;
				default:                 ctrl_data_out = 8'h00;
			endcase
		end
	end

endmodule

// File: logic/lcd_timing.sv
module lcd_timing (
	input  logic                     rst,
	input  logic                     ctrl_clk,
	input  logic                     en,
	input  lcd_pkg::lcd_timing_cfg_t cfg,
	output lcd_pkg::lcd_raw_sync_t   raw,
	output lcd_pkg::cnt_t            h_pos,
	output lcd_pkg::cnt_t            v_pos
);

	lcd_pkg::cnt_t h_cnt;
	lcd_pkg::cnt_t v_cnt;
	logic [8:0]    h_start;
	logic [8:0]    v_start;
	logic [16:0]   h_end;
	logic [16:0]   v_end;
	logic [16:0]   h_total;
	logic [16:0]   v_total;
	logic          h_last;
	logic          v_last;

	// Active area starts after pulse and back porch
	assign h_start = {1'b0, cfg.h_pulse} + {1'b0, cfg.h_back};
	assign v_start = {1'b0, cfg.v_pulse} + {1'b0, cfg.v_back};
	assign h_end   = 17'(h_start) + 17'(cfg.h_res);
	assign v_end   = 17'(v_start) + 17'(cfg.v_res);
	assign h_total = h_end + 17'(cfg.h_front);
	assign v_total = v_end + 17'(cfg.v_front);

	assign h_last = (17'(h_cnt) == h_total - 17'd1);
	assign v_last = (17'(v_cnt) == v_total - 17'd1);

	// Counters sit at zero while disabled
	always_ff @(posedge ctrl_clk or posedge rst)
	begin
		if (rst)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (!en)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_last)
		begin
			h_cnt <= '0;
			if (v_last)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + lcd_pkg::cnt_t'(1);
		end
		else
			h_cnt <= h_cnt + lcd_pkg::cnt_t'(1);
	end

	assign raw.hsync = en && (17'(h_cnt) < 17'(cfg.h_pulse));
	assign raw.vsync = en && (17'(v_cnt) < 17'(cfg.v_pulse));
	assign raw.de    = en &&
		(17'(h_cnt) >= 17'(h_start)) && (17'(h_cnt) < h_end) &&
		(17'(v_cnt) >= 17'(v_start)) && (17'(v_cnt) < v_end);

	// Position inside the active area, meaningless outside it
	assign h_pos = h_cnt - lcd_pkg::cnt_t'(h_start);
	assign v_pos = v_cnt - lcd_pkg::cnt_t'(v_start);

endmodule

// File: logic/lcd_pixel_decode.sv
module lcd_pixel_decode (
	input  lcd_pkg::lcd_pixel_u color_data_in,
	input  logic [7:0]          pixel_size,
	output lcd_pkg::lcd_rgb_t   rgb
);

	// Narrow channels are left aligned, low bits zero
	always_comb
	begin
		case (pixel_size)
			lcd_pkg::PIX_8:
			begin
				rgb.r = {color_data_in.rgb323.r, 5'h00};
				rgb.g = {color_data_in.rgb323.g, 6'h00};
				rgb.b = {color_data_in.rgb323.b, 5'h00};
			end
			lcd_pkg::PIX_16:
			begin
				rgb.r = {color_data_in.rgb565.r, 3'h0};
				rgb.g = {color_data_in.rgb565.g, 2'h0};
				rgb.b = {color_data_in.rgb565.b, 3'h0};
			end
			default:
			begin
				// 24-bit, bytes taken as they are
				rgb.r = color_data_in.rgb24.r;
				rgb.g = color_data_in.rgb24.g;
				rgb.b = color_data_in.rgb24.b;
			end
		endcase
	end

endmodule

// File: logic/lcd_output.sv
module lcd_output (
	input  logic                   rst,
	input  logic                   ctrl_clk,
	input  lcd_pkg::lcd_raw_sync_t raw,
	input  lcd_pkg::lcd_polarity_t pol,
	input  lcd_pkg::lcd_rgb_t      rgb,
	output logic                   lcd_h_sync,
	output logic                   lcd_v_sync,
	output logic                   lcd_de,
	output lcd_pkg::lcd_rgb_t      lcd_color
);

	// All panel pins leave on the same edge
	always_ff @(posedge ctrl_clk or posedge rst)
	begin
		if (rst)
		begin
			lcd_h_sync <= lcd_pkg::RST_POL.hsync_inv;
			lcd_v_sync <= lcd_pkg::RST_POL.vsync_inv;
			lcd_de     <= lcd_pkg::RST_POL.de_inv;
			lcd_color  <= '0;
		end
		else
		begin
			lcd_h_sync <= raw.hsync ^ pol.hsync_inv;
			lcd_v_sync <= raw.vsync ^ pol.vsync_inv;
			lcd_de     <= raw.de ^ pol.de_inv;
			// Blank outside the active area
			lcd_color  <= raw.de ? rgb : '0;
		end
	end

endmodule

// File: logic/lcd_top.sv
module lcd_top (
	input  logic                            rst,
	input  logic                            ctrl_clk,
	input  logic [lcd_pkg::CTRL_ADDR_W-1:0] ctrl_addr,
	input  logic                            ctrl_wr,
	input  logic                            ctrl_rd,
	input  logic [7:0]                      ctrl_data_in,
	output logic [7:0]                      ctrl_data_out,
	input  logic [31:0]                     color_data_in,
	output logic                            lcd_h_sync,
	output logic                            lcd_v_sync,
	output logic                            lcd_de,
	output lcd_pkg::lcd_rgb_t               lcd_color,
	output lcd_pkg::cnt_t                   h_pos,
	output lcd_pkg::cnt_t                   v_pos
);

	lcd_pkg::lcd_timing_cfg_t cfg;
	lcd_pkg::lcd_polarity_t   pol;
	logic                     en;
	logic [7:0]               pixel_size;
	lcd_pkg::lcd_raw_sync_t   raw;
	lcd_pkg::lcd_rgb_t        rgb;

	lcd_regs u_regs (
		.rst          (rst),
		.ctrl_clk     (ctrl_clk),
		.ctrl_addr    (ctrl_addr),
		.ctrl_wr      (ctrl_wr),
		.ctrl_rd      (ctrl_rd),
		.ctrl_data_in (ctrl_data_in),
		.ctrl_data_out(ctrl_data_out),
		.cfg          (cfg),
		.pol          (pol),
		.en           (en),
		.pixel_size   (pixel_size)
	);

	lcd_timing u_timing (
		.rst     (rst),
		.ctrl_clk(ctrl_clk),
		.en      (en),
		.cfg     (cfg),
		.raw     (raw),
		.h_pos   (h_pos),
		.v_pos   (v_pos)
	);

	// Color for the current position arrives in the same cycle
	lcd_pixel_decode u_decode (
		.color_data_in(color_data_in),
		.pixel_size   (pixel_size),
		.rgb          (rgb)
	);

	lcd_output u_output (
		.rst       (rst),
		.ctrl_clk  (ctrl_clk),
		.raw       (raw),
		.pol       (pol),
		.rgb       (rgb),
		.lcd_h_sync(lcd_h_sync),
		.lcd_v_sync(lcd_v_sync),
		.lcd_de    (lcd_de),
		.lcd_color (lcd_color)
	);

endmodule

// File: test/lcd_asserts.sv
module lcd_asserts (
	input logic                   ctrl_clk,
	input logic                   rst,
	input lcd_pkg::lcd_polarity_t pol,
	input logic                   lcd_h_sync,
	input logic                   lcd_v_sync,
	input logic                   lcd_de,
	input lcd_pkg::lcd_rgb_t      lcd_color
);

	// Pins were registered with the polarity of the cycle before
	de_apart_from_hsync: assert property (@(posedge ctrl_clk) disable iff (rst)
		!((lcd_de ^ $past(pol.de_inv)) && (lcd_h_sync ^ $past(pol.hsync_inv))))
		else $error("lcd_de and lcd_h_sync active in the same cycle");

	de_apart_from_vsync: assert property (@(posedge ctrl_clk) disable iff (rst)
		!((lcd_de ^ $past(pol.de_inv)) && (lcd_v_sync ^ $past(pol.vsync_inv))))
		else $error("lcd_de and lcd_v_sync active in the same cycle");

	// No color on the pins while registered de is inactive
	color_blank: assert property (@(posedge ctrl_clk) disable iff (rst)
		!(lcd_de ^ $past(pol.de_inv)) |-> (lcd_color == '0))
		else $error("lcd_color not zero outside the active area");

endmodule

bind lcd_output lcd_asserts u_asserts (
	.ctrl_clk  (ctrl_clk),
	.rst       (rst),
	.pol       (pol),
	.lcd_h_sync(lcd_h_sync),
	.lcd_v_sync(lcd_v_sync),
	.lcd_de    (lcd_de),
	.lcd_color (lcd_color)
);

// File: test/lcd_tb.sv
module lcd_tb;

	logic                            ctrl_clk;
	logic                            rst;
	logic [lcd_pkg::CTRL_ADDR_W-1:0] ctrl_addr;
	logic                            ctrl_wr;
	logic                            ctrl_rd;
	logic [7:0]                      ctrl_data_in;
	logic [7:0]                      ctrl_data_out;
	logic [31:0]                     color_data_in;
	logic                            lcd_h_sync;
	logic                            lcd_v_sync;
	logic                            lcd_de;
	lcd_pkg::lcd_rgb_t               lcd_color;
	lcd_pkg::cnt_t                   h_pos;
	lcd_pkg::cnt_t                   v_pos;

	int          error_count;
	int          test_count;
	int          fail_count;
	int          cycle_count;
	int          cycle_limit = 100000;
	logic [7:0]  cur_size;
	logic [31:0] cur_base;
	logic [23:0] cur_rgb;
	string       cmds[$];

	lcd_top u_dut (
		.rst          (rst),
		.ctrl_clk     (ctrl_clk),
		.ctrl_addr    (ctrl_addr),
		.ctrl_wr      (ctrl_wr),
		.ctrl_rd      (ctrl_rd),
		.ctrl_data_in (ctrl_data_in),
		.ctrl_data_out(ctrl_data_out),
		.color_data_in(color_data_in),
		.lcd_h_sync   (lcd_h_sync),
		.lcd_v_sync   (lcd_v_sync),
		.lcd_de       (lcd_de),
		.lcd_color    (lcd_color),
		.h_pos        (h_pos),
		.v_pos        (v_pos)
	);

	initial
	begin
		ctrl_clk = 1'b0;
		forever #50 ctrl_clk = ~ctrl_clk;
	end

	// Watchdog on the whole run
	initial
	begin
		cycle_count = 0;
		while (cycle_count <= cycle_limit)
		begin
			@(posedge ctrl_clk);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		error_count++;
	endtask

	// Decode per pixel size, red sits at the low end of the word
	function automatic logic [23:0] expected_rgb(input logic [7:0] size,
		input logic [31:0] word);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		if (size == 8'h08)
		begin
			r = {word[2:0], 5'b0};
			g = {word[4:3], 6'b0};
			b = {word[7:5], 5'b0};
		end
		else if (size == 8'h10)
		begin
			r = {word[4:0], 3'b0};
			g = {word[10:5], 2'b0};
			b = {word[15:11], 3'b0};
		end
		else
		begin
			r = word[7:0];
			g = word[15:8];
			b = word[23:16];
		end
		return {r, g, b};
	endfunction

	// Position tag mixed into every byte, so (0,0) gives the base word
	function automatic logic [31:0] color_for(input logic [31:0] base,
		input lcd_pkg::cnt_t h, input lcd_pkg::cnt_t v);
		logic [7:0] tag;
		tag = {h[3:0], v[3:0]};
		return base ^ {tag, tag, tag, tag};
	endfunction

	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
		ctrl_addr = addr;
		ctrl_data_in = data;
		ctrl_wr = 1'b1;
		@(negedge ctrl_clk);
		ctrl_wr = 1'b0;
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		ctrl_addr = addr;
		ctrl_rd = 1'b1;
		@(negedge ctrl_clk);
		got = ctrl_data_out;
		ctrl_rd = 1'b0;
		if (got !== exp)
			report_mismatch($sformatf("ctrl_data_out at 0x%04h", addr), 32'(got), 32'(exp));
	endtask

	task automatic check_idle(input logic hs, input logic vs, input logic de,
		input logic [23:0] color, input int n);
		repeat (n)
		begin
			if (lcd_h_sync !== hs)
				report_mismatch("lcd_h_sync", 32'(lcd_h_sync), 32'(hs));
			if (lcd_v_sync !== vs)
				report_mismatch("lcd_v_sync", 32'(lcd_v_sync), 32'(vs));
			if (lcd_de !== de)
				report_mismatch("lcd_de", 32'(lcd_de), 32'(de));
			if (lcd_color !== color)
				report_mismatch("lcd_color", 32'(lcd_color), 32'(color));
			@(negedge ctrl_clk);
		end
	endtask

	task automatic set_format(input logic [7:0] size, input logic [31:0] base,
		input logic [23:0] rgb);
		write_reg(lcd_pkg::LCD_BASE_ADDR + 16'(lcd_pkg::REG_PIXEL_SIZE), size);
		read_check(lcd_pkg::LCD_BASE_ADDR + 16'(lcd_pkg::REG_PIXEL_SIZE), size);
		cur_size = size;
		cur_base = base;
		cur_rgb = rgb;
	endtask

	// Enable, watch the pins for a number of cycles, then disable mid-frame
	task automatic run_frame(input logic [7:0] ctrl, input int cycles, input int exp_de,
		input int h_res, input int v_res, input int h_gap, input int v_gap);
		logic [31:0]   prev_color;
		lcd_pkg::cnt_t prev_h;
		lcd_pkg::cnt_t prev_v;
		logic          hs_act;
		logic          vs_act;
		logic          hs_was;
		logic          vs_was;
		logic [23:0]   exp_color;
		int            de_first;
		int            de_index;
		int            last_hs;
		int            last_vs;
		hs_was = 1'b0;
		vs_was = 1'b0;
		de_first = 0;
		de_index = 0;
		last_hs = -1;
		last_vs = -1;
		write_reg(lcd_pkg::LCD_BASE_ADDR + 16'(lcd_pkg::REG_CTRL), ctrl);
		prev_h = h_pos;
		prev_v = v_pos;
		prev_color = color_for(cur_base, prev_h, prev_v);
		color_data_in = prev_color;
		for (int i = 1; i <= cycles; i++)
		begin
			@(negedge ctrl_clk);
			hs_act = lcd_h_sync ^ ctrl[3];
			vs_act = lcd_v_sync ^ ctrl[2];
			if (hs_act && !hs_was)
			begin
				if (last_hs >= 0 && i - last_hs != h_gap)
					report_mismatch("hsync start spacing", 32'(i - last_hs), 32'(h_gap));
				last_hs = i;
			end
			if (vs_act && !vs_was)
			begin
				if (last_vs >= 0 && i - last_vs != v_gap)
					report_mismatch("vsync start spacing", 32'(i - last_vs), 32'(v_gap));
				last_vs = i;
			end
			if (lcd_de ^ ctrl[1])
			begin
				if (i <= v_gap)
					de_first++;
				if (int'(prev_h) != de_index % h_res)
					report_mismatch("h_pos", 32'(prev_h), 32'(de_index % h_res));
				if (int'(prev_v) != (de_index / h_res) % v_res)
					report_mismatch("v_pos", 32'(prev_v), 32'((de_index / h_res) % v_res));
				exp_color = expected_rgb(cur_size, prev_color);
				if (prev_h == '0 && prev_v == '0)
					exp_color = cur_rgb;
				if (lcd_color !== exp_color)
					report_mismatch("lcd_color", 32'(lcd_color), 32'(exp_color));
				de_index++;
			end
			else if (lcd_color !== 24'h0)
				report_mismatch("lcd_color outside de", 32'(lcd_color), 32'h0);
			hs_was = hs_act;
			vs_was = vs_act;
			prev_h = h_pos;
			prev_v = v_pos;
			prev_color = color_for(cur_base, prev_h, prev_v);
			color_data_in = prev_color;
		end
		if (de_first != exp_de)
			report_mismatch("de count in first frame", 32'(de_first), 32'(exp_de));
		if (last_vs < 0)
		begin
			$display("No vsync pulse was seen while the controller was enabled");
			error_count++;
		end
		// Pins go idle on the edge after en clears
		write_reg(lcd_pkg::LCD_BASE_ADDR + 16'(lcd_pkg::REG_CTRL), ctrl & 8'hfe);
		@(negedge ctrl_clk);
		check_idle(ctrl[3], ctrl[2], ctrl[1], 24'h0, 8);
	endtask

	initial
	begin
		int          fd;
		int          code;
		int          max_frame;
		int          errs_before;
		string       line;
		string       rest;
		byte         c;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		logic [31:0] a4;
		logic [31:0] a5;
		logic [31:0] a6;
		rst = 1'b1;
		ctrl_addr = '0;
		ctrl_wr = 1'b0;
		ctrl_rd = 1'b0;
		ctrl_data_in = 8'h00;
		color_data_in = 32'h0;
		cur_size = 8'h10;
		cur_base = 32'h0;
		cur_rgb = 24'h0;
		error_count = 0;
		test_count = 0;
		fail_count = 0;
		max_frame = 0;
		fd = $fopen("test/lcd_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open test/lcd_tests.txt, no tests were run");
			error_count++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line.getc(0) != "#")
				begin
					if (line.getc(line.len() - 1) == 8'h0a)
						line = line.substr(0, line.len() - 2);
					cmds.push_back(line);
					if (line.getc(0) == "F")
					begin
						code = $sscanf(line.substr(1, line.len() - 1), "%h %h", a0, a1);
						if (int'(a1) > max_frame)
							max_frame = int'(a1);
					end
				end
			end
			$fclose(fd);
			cycle_limit = (cmds.size() + 10) * (max_frame + 20) + 100;
		end
		repeat (10) @(negedge ctrl_clk);
		rst = 1'b0;
		foreach (cmds[i])
		begin
			c = cmds[i].getc(0);
			rest = cmds[i].substr(1, cmds[i].len() - 1);
			code = $sscanf(rest, "%h %h %h %h %h %h %h", a0, a1, a2, a3, a4, a5, a6);
			errs_before = error_count;
			case (c)
				"P": check_idle(a0[0], a1[0], a2[0], a3[23:0], 1);
				"R": read_check(a0[15:0], a1[7:0]);
				"W": write_reg(a0[15:0], a1[7:0]);
				"S": set_format(a0[7:0], a1, a2[23:0]);
				"F": run_frame(a0[7:0], int'(a1), int'(a2), int'(a3), int'(a4), int'(a5),
					int'(a6));
				default:
				begin
					$display("Unknown command in the tests file: %s", cmds[i]);
					error_count++;
				end
			endcase
			test_count++;
			if (error_count != errs_before)
			begin
				fail_count++;
				$display("test %0d [%s]: failed", test_count, cmds[i]);
			end
			else
				$display("test %0d [%s]: ok", test_count, cmds[i]);
		end
		$display("Tests run: %0d, failed: %0d, mismatches: %0d",
			test_count, fail_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: test/lcd_tests.txt
# Columns in hex: P hsync vsync de color | R addr data | W addr data
# S size word rgb | F ctrl cycles de_count h_res v_res h_gap v_gap
P 1 1 0 000000
R 0040 0c
R 0041 20
R 0042 03
R 0043 02
R 0044 2e
R 0045 d2
R 0046 e0
R 0047 01
R 0048 02
R 0049 17
R 004a 16
R 004b 10
R 004c 00
R 0050 00
W 0042 12
R 0042 03
W 0041 34
R 0041 34
R 0042 12
W 0042 00
W 0041 04
W 0043 01
W 0044 02
W 0045 01
W 0047 00
R 0047 01
W 0046 03
R 0046 03
R 0047 00
W 0048 01
W 0049 01
W 004a 01
R 0043 01
R 0044 02
R 0045 01
R 0048 01
R 0049 01
R 004a 01
S 08 5a5a5a6e c04060
F 0d 76 0c 4 3 8 30
S 10 ffff8a53 984888
F 03 76 0c 4 3 8 30
S 18 ab123456 563412
F 0f 76 0c 4 3 8 30
P 1 1 1 000000
R 0040 0e

// File: verilog.f
logic/lcd_pkg.sv
logic/lcd_regs.sv
logic/lcd_timing.sv
logic/lcd_pixel_decode.sv
logic/lcd_output.sv
logic/lcd_top.sv
test/lcd_asserts.sv
test/lcd_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lcd_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "ERRORS FOUND" >> $(LOG)
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
